// ==== scan_cfg.svh ====
/*
 * Scan configuration block build constants
 * Cell widths, chain length, shift direction, reset value
 * and APB register byte offsets
 */
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// Cell widths in chain order from the TDO end
`define SCAN_CELL0_W 8
`define SCAN_CELL1_W 16
`define SCAN_CELL2_W 8

// Whole chain, sum of the three cells
`define SCAN_CHAIN_W 32

// 1 shifts toward bit 0, serial input enters the MSB
`define SCAN_LSB_FIRST 1

// Value after reset and after a CLEAR command
`define SCAN_RESET_VAL 0

// APB byte offsets
`define SCAN_ADDR_TDI 4'h0
`define SCAN_ADDR_TDO 4'h4
`define SCAN_ADDR_CMD 4'h8
`define SCAN_ADDR_STATUS 4'hC

`endif

// ==== scan_bus_pkg.sv ====
/*
 * APB side types of the scan configuration block
 * Request and response structs, register offset enum
 */
`include "scan_cfg.svh"

package scan_bus_pkg;

	// **************************************************************************
	// APB transfer
	// **************************************************************************

	// Host to slave, one set per clock
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		// Byte offset inside the 16-byte window
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Slave to host
	typedef struct packed {
		logic [31:0] prdata;
		// Tied high, no wait states
		logic pready;
		// Rejected write while the sequencer runs
		logic pslverr;
	} apb_rsp_t;

	// **************************************************************************
	// Register map
	// **************************************************************************

	// Offsets taken from the build constants
	typedef enum logic [3:0] {
		REG_TDI = `SCAN_ADDR_TDI,
		REG_TDO = `SCAN_ADDR_TDO,
		REG_CMD = `SCAN_ADDR_CMD,
		REG_STATUS = `SCAN_ADDR_STATUS
	} scan_reg_e;

endpackage

// ==== scan_chain_pkg.sv ====
/*
 * Scan chain side types
 * Cell control struct, opcode enum, command word union
 * with shift and operation views, command handoff struct
 */
package scan_chain_pkg;

	// **************************************************************************
	// Controls to the cells
	// **************************************************************************

	// One-cycle pulses, at most one operation bit high
	typedef struct packed {
		logic clear;
		logic capture;
		logic update;
		logic shift;
		// Serial input into the chain head
		logic tdi;
	} scan_ctl_t;

	// **************************************************************************
	// Command word
	// **************************************************************************

	typedef enum logic [1:0] {
		SHIFT = 2'd0,
		CAPTURE = 2'd1,
		UPDATE = 2'd2,
		CLEAR = 2'd3
	} scan_op_e;

	// Shift view, count 0 is a no-op
	typedef struct packed {
		scan_op_e op;
		logic [5:0] count;
		// Host side hint, the TDI register is never altered by a shift
		logic keep_tdi;
		logic [6:0] rsvd;
	} scan_shift_view_t;

	// Single operation view
	typedef struct packed {
		scan_op_e op;
		// Operation flags, no repeat
		logic [7:0] flags;
		logic [5:0] rsvd;
	} scan_op_view_t;

	// Opcode sits on bits 15:14 in both views
	typedef union packed {
		scan_shift_view_t shift_v;
		scan_op_view_t op_v;
	} scan_cmd_u;

	// Register block to sequencer handoff
	typedef struct packed {
		logic valid;
		scan_cmd_u cmd;
	} scan_cmd_t;

endpackage

// ==== scan_cell_reg.sv ====
/*
 * Scan cell register
 * Rising-edge master stage for clear, capture and shift,
 * falling-edge shadow stage holding the update value
 */
`timescale 1ns/100ps

module scan_cell_reg #(
	parameter int width = 8,
	parameter bit lsb_first = 1'b1,
	parameter logic [width-1:0] reset_val = '0
) (
	input logic rvx_port_04,
	input logic rvx_port_00,
	input scan_chain_pkg::scan_ctl_t ctl,
	input logic scan_in,
	input logic [width-1:0] capture_data,
	output logic [width-1:0] update_data,
	output logic scan_out
);

	logic [width-1:0] master_q;
	logic [width-1:0] shadow_q;

	// Master stage
	// Clear beats capture, capture beats shift
	always_ff @(posedge rvx_port_04 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
			master_q <= reset_val;
		else if (ctl.clear)
			master_q <= reset_val;
		else if (ctl.capture)
			master_q <= capture_data;
		else if (ctl.shift)
		begin
			if (lsb_first)
				master_q <= {scan_in, master_q[width-1:1]};
			else
				master_q <= {master_q[width-2:0], scan_in};
		end
	end

	// Bit leaving the cell toward the next one
	assign scan_out = lsb_first ? master_q[0] : master_q[width-1];

	// Shadow stage, half a cycle behind the master
	always_ff @(negedge rvx_port_04 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
			shadow_q <= reset_val;
		else if (ctl.clear)
			shadow_q <= reset_val;
		else if (ctl.update)
			shadow_q <= master_q;
	end

	// Parallel configuration bits
	assign update_data = shadow_q;

	// Sequencer must never ask for a capture and a shift in one cycle
	a_cap_shift_excl : assert property (
		@(posedge rvx_port_04) disable iff (!rvx_port_00)
		!(ctl.capture && ctl.shift)
	);

endmodule

// ==== scan_sequencer.sv ====
/*
 * Scan command sequencer
 * Runs shift counts and single operations, feeds the chain
 * serial input and collects returning bits into the TDO word
 */
`timescale 1ns/100ps
`include "scan_cfg.svh"

module scan_sequencer (
	input logic rvx_port_04,
	input logic rvx_port_00,
	input scan_chain_pkg::scan_cmd_t cmd,
	input logic [`SCAN_CHAIN_W-1:0] tdi_word,
	input logic tdo_bit,
	output scan_chain_pkg::scan_ctl_t ctl,
	output logic [`SCAN_CHAIN_W-1:0] tdo_word,
	output logic busy
);

	localparam int idx_w = $clog2(`SCAN_CHAIN_W);

	scan_chain_pkg::scan_ctl_t ctl_q;
	// Shifts still to go after the current one
	logic [5:0] cnt_q;
	// TDI bit for the next shift
	logic [idx_w-1:0] idx_q;
	logic [`SCAN_CHAIN_W-1:0] tdo_q;
	logic pulse;

	// Any operation pulse on the cells this cycle
	assign pulse = ctl_q.clear | ctl_q.capture | ctl_q.update | ctl_q.shift;

	// **************************************************************************
	// Command engine
	// **************************************************************************

	always_ff @(posedge rvx_port_04 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			ctl_q <= '0;
			cnt_q <= '0;
			idx_q <= '0;
		end
		else if (cmd.valid)
		begin
			ctl_q <= '0;
			cnt_q <= '0;
			idx_q <= '0;
			// Opcode picks the view
			case (cmd.cmd.op_v.op)
				scan_chain_pkg::SHIFT:
				begin
					// Count 0 finishes with no pulse at all
					if (cmd.cmd.shift_v.count != 6'd0)
					begin
						ctl_q.shift <= 1'b1;
						ctl_q.tdi <= tdi_word[0];
						cnt_q <= cmd.cmd.shift_v.count - 6'd1;
						idx_q <= idx_w'(1);
					end
				end
				scan_chain_pkg::CAPTURE:
					ctl_q.capture <= 1'b1;
				scan_chain_pkg::UPDATE:
					ctl_q.update <= 1'b1;
				scan_chain_pkg::CLEAR:
					ctl_q.clear <= 1'b1;
				default:
					ctl_q <= '0;
			endcase
		end
		else if (ctl_q.shift && (cnt_q != 6'd0))
		begin
			// Next bit of the TDI word, index wraps past the chain end
			ctl_q.tdi <= tdi_word[idx_q];
			cnt_q <= cnt_q - 6'd1;
			idx_q <= idx_q + idx_w'(1);
		end
		else
			ctl_q <= '0;
	end

	// **************************************************************************
	// Read-back
	// **************************************************************************

	// Bit leaving the chain on a shift edge enters the TDO MSB
	always_ff @(posedge rvx_port_04 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
			tdo_q <= `SCAN_RESET_VAL;
		else if (ctl_q.shift)
			tdo_q <= {tdo_bit, tdo_q[`SCAN_CHAIN_W-1:1]};
	end

	assign ctl = ctl_q;
	assign tdo_word = tdo_q;
	// High from the handoff cycle through the last pulse
	assign busy = cmd.valid | pulse;

	// Register block has to hold commands back while a run is active
	a_no_cmd_busy : assert property (
		@(posedge rvx_port_04) disable iff (!rvx_port_00)
		cmd.valid |-> !pulse
	);

	// One operation at a time on the chain
	a_one_op : assert property (
		@(posedge rvx_port_04) disable iff (!rvx_port_00)
		$onehot0({ctl_q.clear, ctl_q.capture, ctl_q.update, ctl_q.shift})
	);

endmodule

// ==== scan_apb_regs.sv ====
/*
 * APB register block for the scan chain
 * TDI, TDO, CMD and STATUS registers, zero wait states,
 * error response on TDI or CMD writes while busy
 */
`timescale 1ns/100ps
`include "scan_cfg.svh"

module scan_apb_regs (
	input logic rvx_port_04,
	input logic rvx_port_00,
	input scan_bus_pkg::apb_req_t req,
	output scan_bus_pkg::apb_rsp_t rsp,
	input logic busy,
	input logic [`SCAN_CHAIN_W-1:0] tdo_word,
	output logic [`SCAN_CHAIN_W-1:0] tdi_word,
	output scan_chain_pkg::scan_cmd_t cmd
);

	localparam int cmd_w = $bits(scan_chain_pkg::scan_cmd_u);

	logic [`SCAN_CHAIN_W-1:0] tdi_q;
	scan_chain_pkg::scan_cmd_u cmd_q;
	logic valid_q;
	logic access;
	logic wr_en;
	logic rd_en;
	logic hit_tdi;
	logic hit_cmd;
	logic wr_err;
	logic [31:0] rd_data;

	// **************************************************************************
	// Decode
	// **************************************************************************

	// Access phase, completes in this cycle
	assign access = req.psel & req.penable;
	assign wr_en = access & req.pwrite;
	assign rd_en = access & ~req.pwrite;

	assign hit_tdi = (req.paddr == scan_bus_pkg::REG_TDI);
	assign hit_cmd = (req.paddr == scan_bus_pkg::REG_CMD);

	// Writes that would disturb a running sequence
	assign wr_err = wr_en & busy & (hit_tdi | hit_cmd);

	// **************************************************************************
	// Registers
	// **************************************************************************

	// TDI word, dropped while busy
	always_ff @(posedge rvx_port_04 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
			tdi_q <= `SCAN_RESET_VAL;
		else if (wr_en && hit_tdi && !busy)
			tdi_q <= req.pwdata;
	end

	// Command word and its one-cycle valid
	always_ff @(posedge rvx_port_04 or negedge rvx_port_00)
	begin
		if (!rvx_port_00)
		begin
			cmd_q <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			if (wr_en && hit_cmd && !busy)
			begin
				cmd_q <= req.pwdata[cmd_w-1:0];
				valid_q <= 1'b1;
			end
		end
	end

	// **************************************************************************
	// Read data
	// **************************************************************************

	always_comb
	begin
		rd_data = '0;
		case (req.paddr)
			scan_bus_pkg::REG_TDI:
				rd_data = tdi_q;
			scan_bus_pkg::REG_TDO:
				rd_data = tdo_word;
			scan_bus_pkg::REG_CMD:
				rd_data = {{(32-cmd_w){1'b0}}, cmd_q};
			scan_bus_pkg::REG_STATUS:
				rd_data = {31'b0, busy};    // Bit 0 busy
			default:
				rd_data = '0;
		endcase
	end

	assign rsp.prdata = rd_en ? rd_data : '0;
	assign rsp.pready = 1'b1;
	assign rsp.pslverr = wr_err;

	assign tdi_word = tdi_q;
	assign cmd.valid = valid_q;
	assign cmd.cmd = cmd_q;

	// Host keeps psel up across the whole transfer
	a_penable_psel : assert property (
		@(posedge rvx_port_04) disable iff (!rvx_port_00)
		req.penable |-> req.psel
	);

endmodule

// ==== scan_subsys_top.sv ====
/*
 * Scan configuration subsystem top
 * APB registers, command sequencer and a three-cell chain
 */
`timescale 1ns/100ps
`include "scan_cfg.svh"

module scan_subsys_top (
	input logic rvx_port_04,
	input logic rvx_port_00,
	input scan_bus_pkg::apb_req_t apb_req,
	output scan_bus_pkg::apb_rsp_t apb_rsp,
	input logic [`SCAN_CHAIN_W-1:0] status_in,
	output logic [`SCAN_CHAIN_W-1:0] cfg_out
);

	// Bit boundaries of the chain word {cell2, cell1, cell0}
	localparam int c1_lo = `SCAN_CELL0_W;
	localparam int c2_lo = `SCAN_CELL0_W + `SCAN_CELL1_W;

	scan_chain_pkg::scan_ctl_t ctl;
	scan_chain_pkg::scan_cmd_t cmd;
	logic [`SCAN_CHAIN_W-1:0] tdi_word;
	logic [`SCAN_CHAIN_W-1:0] tdo_word;
	logic busy;
	// Serial links, head to tail
	logic so2;
	logic so1;
	logic tdo;

	scan_apb_regs u_regs (
		.rvx_port_04(rvx_port_04),
		.rvx_port_00(rvx_port_00),
		.req(apb_req),
		.rsp(apb_rsp),
		.busy(busy),
		.tdo_word(tdo_word),
		.tdi_word(tdi_word),
		.cmd(cmd)
	);

	scan_sequencer u_seq (
		.rvx_port_04(rvx_port_04),
		.rvx_port_00(rvx_port_00),
		.cmd(cmd),
		.tdi_word(tdi_word),
		.tdo_bit(tdo),
		.ctl(ctl),
		.tdo_word(tdo_word),
		.busy(busy)
	);

	// **************************************************************************
	// Chain, tdi enters cell2 and leaves from cell0
	// **************************************************************************

	scan_cell_reg #(
		.width(`SCAN_CELL2_W),
		.lsb_first(`SCAN_LSB_FIRST),
		.reset_val(`SCAN_RESET_VAL)
	) cell2 (
		.rvx_port_04(rvx_port_04),
		.rvx_port_00(rvx_port_00),
		.ctl(ctl),
		.scan_in(ctl.tdi),
		.capture_data(status_in[`SCAN_CHAIN_W-1:c2_lo]),
		.update_data(cfg_out[`SCAN_CHAIN_W-1:c2_lo]),
		.scan_out(so2)
	);

	scan_cell_reg #(
		.width(`SCAN_CELL1_W),
		.lsb_first(`SCAN_LSB_FIRST),
		.reset_val(`SCAN_RESET_VAL)
	) cell1 (
		.rvx_port_04(rvx_port_04),
		.rvx_port_00(rvx_port_00),
		.ctl(ctl),
		.scan_in(so2),
		.capture_data(status_in[c2_lo-1:c1_lo]),
		.update_data(cfg_out[c2_lo-1:c1_lo]),
		.scan_out(so1)
	);

	scan_cell_reg #(
		.width(`SCAN_CELL0_W),
		.lsb_first(`SCAN_LSB_FIRST),
		.reset_val(`SCAN_RESET_VAL)
	) cell0 (
		.rvx_port_04(rvx_port_04),
		.rvx_port_00(rvx_port_00),
		.ctl(ctl),
		.scan_in(so1),
		.capture_data(status_in[c1_lo-1:0]),
		.update_data(cfg_out[c1_lo-1:0]),
		.scan_out(tdo)
	);

endmodule

// ==== tb_scan_subsys.sv ====
/*
 * Testbench for the scan configuration subsystem
 * Clock, reset, LCG stimulus, APB tasks, chain model,
 * compare tasks and the directed plus random test sequence
 */
`timescale 1ns/100ps
`include "scan_cfg.svh"

module tb_scan_subsys;

	localparam int half_period = 20;
	localparam int quarter_period = 10;
	// STATUS reads before a wait gives up
	localparam int poll_limit = 200;

	logic rvx_port_04;
	logic rvx_port_00;
	scan_bus_pkg::apb_req_t apb_req;
	scan_bus_pkg::apb_rsp_t apb_rsp;
	logic [`SCAN_CHAIN_W-1:0] status_in;
	logic [`SCAN_CHAIN_W-1:0] cfg_out;

	logic [31:0] rand_state;
	int err_count;

	// Reference model of the chain, the shadow stages and the read-back
	logic [`SCAN_CHAIN_W-1:0] chain_m;
	logic [`SCAN_CHAIN_W-1:0] shadow_m;
	logic [`SCAN_CHAIN_W-1:0] tdo_m;
	logic [`SCAN_CHAIN_W-1:0] tdi_m;

	scan_subsys_top dut0 (
		.rvx_port_04(rvx_port_04),
		.rvx_port_00(rvx_port_00),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.status_in(status_in),
		.cfg_out(cfg_out)
	);

	// 40 ns clock
	initial
	begin
		rvx_port_04 = 1'b0;
		forever
			#half_period rvx_port_04 = ~rvx_port_04;
	end

	function logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// **************************************************************************
	// Compare tasks
	// **************************************************************************

	task check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			err_count++;
		end
	endtask

	task check_err(input string name, input logic exp, input scan_bus_pkg::apb_rsp_t rsp);
		if (rsp.pslverr !== exp)
		begin
			$display("FAIL %s expected pslverr %b actual %b", name, exp, rsp.pslverr);
			err_count++;
		end
	endtask

	task check_cfg(input string name, input logic [`SCAN_CHAIN_W-1:0] exp,
		input logic [`SCAN_CHAIN_W-1:0] act);
		if (act !== exp)
		begin
			$display("FAIL %s expected cfg %h actual %h", name, exp, act);
			err_count++;
		end
	endtask

	// **************************************************************************
	// APB host
	// **************************************************************************

	// Setup, access and idle phases driven on falling edges
	task apb_write(input logic [3:0] addr, input logic [31:0] data,
		output scan_bus_pkg::apb_rsp_t rsp);
		@(negedge rvx_port_04);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(negedge rvx_port_04);
		apb_req.penable = 1'b1;
		// Response sampled mid low phase before the access edge
		#quarter_period rsp = apb_rsp;
		@(negedge rvx_port_04);
		apb_req = '0;
	endtask

	task apb_read(input logic [3:0] addr, output logic [31:0] data);
		@(negedge rvx_port_04);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = addr;
		apb_req.pwdata = '0;
		@(negedge rvx_port_04);
		apb_req.penable = 1'b1;
		#quarter_period data = apb_rsp.prdata;
		@(negedge rvx_port_04);
		apb_req = '0;
	endtask

	// Poll STATUS bit 0 until the sequencer is idle
	task wait_idle(input string name);
		logic [31:0] st;
		int polls;
		st = 32'h1;
		polls = 0;
		while (st[0] && (polls < poll_limit))
		begin
			apb_read(`SCAN_ADDR_STATUS, st);
			polls++;
		end
		if (st[0])
		begin
			$display("Timeout in %s, busy still set after %0d STATUS reads", name, polls);
			$display("tests failed");
			$finish;
		end
	endtask

	// **************************************************************************
	// Chain model
	// **************************************************************************

	// Right shift of {cell2, cell1, cell0}
	// TDI bit i enters bit 31 on shift i
	task model_shift(input int n);
		int i;
		logic out_bit;
		for (i = 0; i < n; i++)
		begin
			out_bit = chain_m[0];
			chain_m = {tdi_m[i % `SCAN_CHAIN_W], chain_m[`SCAN_CHAIN_W-1:1]};
			tdo_m = {out_bit, tdo_m[`SCAN_CHAIN_W-1:1]};
		end
	endtask

	// **************************************************************************
	// Command helpers
	// **************************************************************************

	task send_cmd(input string name, input scan_chain_pkg::scan_op_e op,
		input logic [5:0] count);
		scan_chain_pkg::scan_cmd_u c;
		scan_bus_pkg::apb_rsp_t rsp;
		c = '0;
		if (op == scan_chain_pkg::SHIFT)
		begin
			c.shift_v.op = op;
			c.shift_v.count = count;
		end
		else
			c.op_v.op = op;
		apb_write(`SCAN_ADDR_CMD, {16'h0, c}, rsp);
		check_err(name, 1'b0, rsp);
	endtask

	// Issue the command and wait for completion before advancing the model
	task run_cmd(input string name, input scan_chain_pkg::scan_op_e op,
		input logic [5:0] count);
		send_cmd(name, op, count);
		wait_idle(name);
		case (op)
			scan_chain_pkg::SHIFT:
				model_shift(count);
			scan_chain_pkg::CAPTURE:
				chain_m = status_in;
			scan_chain_pkg::UPDATE:
				shadow_m = chain_m;
			default:
			begin
				chain_m = `SCAN_RESET_VAL;
				shadow_m = `SCAN_RESET_VAL;
			end
		endcase
	endtask

	task write_tdi(input string name, input logic [31:0] data);
		scan_bus_pkg::apb_rsp_t rsp;
		apb_write(`SCAN_ADDR_TDI, data, rsp);
		check_err(name, 1'b0, rsp);
		tdi_m = data;
	endtask

	task check_tdo(input string name);
		logic [31:0] d;
		apb_read(`SCAN_ADDR_TDO, d);
		check_word(name, tdo_m, d);
	endtask

	// **************************************************************************
	// Test sequence
	// **************************************************************************

	initial
	begin
		logic [31:0] rd;
		logic [31:0] r;
		logic [31:0] sv;
		scan_bus_pkg::apb_rsp_t rsp;
		scan_chain_pkg::scan_cmd_u busy_cmd;
		int k;
		int n;

		rvx_port_00 = 1'b0;
		apb_req = '0;
		status_in = '0;
		rand_state = 32'hd9fc_3d3e;
		err_count = 0;
		chain_m = '0;
		shadow_m = '0;
		tdo_m = '0;
		tdi_m = '0;
		repeat (2) @(posedge rvx_port_04);
		@(negedge rvx_port_04);
		rvx_port_00 = 1'b1;

		// Reset state
		apb_read(`SCAN_ADDR_STATUS, rd);
		check_word("reset status", 32'h0, rd);
		apb_read(`SCAN_ADDR_TDO, rd);
		check_word("reset tdo", 32'h0, rd);
		check_cfg("reset cfg", '0, cfg_out);

		// Full load and update with TDO returning the old chain
		write_tdi("load tdi", next_rand());
		run_cmd("shift 32", scan_chain_pkg::SHIFT, 6'd32);
		check_tdo("shift 32 tdo");
		apb_read(`SCAN_ADDR_TDI, rd);
		check_word("tdi kept", tdi_m, rd);
		run_cmd("update", scan_chain_pkg::UPDATE, 6'd0);
		check_cfg("update cfg", tdi_m, cfg_out);

		// Capture then read back through the chain
		@(negedge rvx_port_04);
		status_in = next_rand();
		sv = status_in;
		run_cmd("capture", scan_chain_pkg::CAPTURE, 6'd0);
		// Fresh TDI word so the following update moves cfg
		write_tdi("capture tdi", next_rand());
		run_cmd("capture shift", scan_chain_pkg::SHIFT, 6'd32);
		apb_read(`SCAN_ADDR_TDO, rd);
		check_word("capture tdo", sv, rd);
		check_cfg("cfg held", shadow_m, cfg_out);
		run_cmd("capture update", scan_chain_pkg::UPDATE, 6'd0);
		check_cfg("capture cfg", shadow_m, cfg_out);

		// Random partial shifts, updates and captures
		for (k = 0; k < 12; k++)
		begin
			write_tdi("rand tdi", next_rand());
			r = next_rand();
			n = ((r >> 8) % 31) + 1;
			if (r[28])
			begin
				@(negedge rvx_port_04);
				status_in = next_rand();
				run_cmd("rand capture", scan_chain_pkg::CAPTURE, 6'd0);
			end
			run_cmd("rand shift", scan_chain_pkg::SHIFT, n[5:0]);
			check_tdo("rand tdo");
			if (r[24])
			begin
				run_cmd("rand update", scan_chain_pkg::UPDATE, 6'd0);
				check_cfg("rand cfg", shadow_m, cfg_out);
			end
		end

		// Writes during a run are rejected and leave the run alone
		write_tdi("busy tdi", next_rand());
		send_cmd("busy shift", scan_chain_pkg::SHIFT, 6'd32);
		busy_cmd = '0;
		busy_cmd.op_v.op = scan_chain_pkg::UPDATE;
		apb_write(`SCAN_ADDR_CMD, {16'h0, busy_cmd}, rsp);
		check_err("cmd while busy", 1'b1, rsp);
		apb_write(`SCAN_ADDR_TDI, next_rand(), rsp);
		check_err("tdi while busy", 1'b1, rsp);
		wait_idle("busy shift");
		model_shift(32);
		check_tdo("busy tdo");
		apb_read(`SCAN_ADDR_TDI, rd);
		check_word("busy tdi kept", tdi_m, rd);
		run_cmd("busy update", scan_chain_pkg::UPDATE, 6'd0);
		check_cfg("busy cfg", shadow_m, cfg_out);

		// Clear then update brings cfg back to zero
		run_cmd("clear", scan_chain_pkg::CLEAR, 6'd0);
		run_cmd("clear update", scan_chain_pkg::UPDATE, 6'd0);
		check_cfg("clear cfg", '0, cfg_out);
		run_cmd("clear shift", scan_chain_pkg::SHIFT, 6'd32);
		apb_read(`SCAN_ADDR_TDO, rd);
		check_word("clear tdo", 32'h0, rd);

		$display("Error count: %0d", err_count);
		if (err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+.
scan_bus_pkg.sv
scan_chain_pkg.sv
scan_cell_reg.sv
scan_sequencer.sv
scan_apb_regs.sv
scan_subsys_top.sv
tb_scan_subsys.sv
